// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cm3_system \
		-f sources.f -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== hdl/ahb_decoder_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_decoder_mux (
  input  logic                              hclk,
  input  logic                              reset_i,
  input  logic [cm3_bus_pkg::ADDR_W-1:0]    haddr_i,
  input  cm3_bus_pkg::htrans_t              htrans_i,
  input  cm3_bus_pkg::hsize_t               hsize_i,
  input  logic                              hwrite_i,
  input  logic [cm3_bus_pkg::DATA_W-1:0]    hwdata_i,
  ahb_slv_if.master                         ram_o,
  ahb_slv_if.master                         mac_o,
  ahb_slv_if.master                         def_o,
  output logic [cm3_bus_pkg::DATA_W-1:0]    hrdata_o,
  output logic                              hready_o,
  output cm3_bus_pkg::hresp_t               hresp_o
);
  import cm3_bus_pkg::*;

  slave_sel_t asel;                             // address-phase decode
  slave_sel_t dsel_q;                           // data-phase owner

  always_comb begin
    asel = '0;
    if (haddr_i[ADDR_W-1 -: 4] == RAM_BASE[ADDR_W-1 -: 4]) begin
      asel.ram = 1'b1;
    end else if (haddr_i[ADDR_W-1 -: 4] == MAC_BASE[ADDR_W-1 -: 4]) begin
      asel.mac = 1'b1;
    end else begin
      asel.dflt = 1'b1;                         // everything else errors
    end
  end

  // request fan-out, slaves qualify sel with trans and ready
  assign ram_o.sel   = asel.ram;
  assign ram_o.trans = htrans_i;
  assign ram_o.size  = hsize_i;
  assign ram_o.write = hwrite_i;
  assign ram_o.addr  = haddr_i;
  assign ram_o.wdata = hwdata_i;
  assign ram_o.ready = hready_o;

  assign mac_o.sel   = asel.mac;
  assign mac_o.trans = htrans_i;
  assign mac_o.size  = hsize_i;
  assign mac_o.write = hwrite_i;
  assign mac_o.addr  = haddr_i;
  assign mac_o.wdata = hwdata_i;
  assign mac_o.ready = hready_o;

  assign def_o.sel   = asel.dflt;
  assign def_o.trans = htrans_i;
  assign def_o.size  = hsize_i;
  assign def_o.write = hwrite_i;
  assign def_o.addr  = haddr_i;
  assign def_o.wdata = hwdata_i;
  assign def_o.ready = hready_o;

  // select moves only when the current data phase completes
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      dsel_q <= '0;
    end else if (hready_o) begin
      dsel_q <= trans_active(htrans_i) ? asel : '0;  // idle -> no owner
    end
  end

  always_comb begin
    hready_o = 1'b1;                            // no owner gives ready + okay
    hresp_o  = HRESP_OKAY;
    hrdata_o = '0;
    if (dsel_q.ram) begin
      hready_o = ram_o.readyout;
      hresp_o  = ram_o.resp;
      hrdata_o = ram_o.rdata;
    end else if (dsel_q.mac) begin
      hready_o = mac_o.readyout;
      hresp_o  = mac_o.resp;
      hrdata_o = mac_o.rdata;
    end else if (dsel_q.dflt) begin
      hready_o = def_o.readyout;
      hresp_o  = def_o.resp;
      hrdata_o = def_o.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ahb_default_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_default_slave (
  input  logic      hclk,
  input  logic      reset_i,
  ahb_slv_if.slave  bus
);
  import cm3_bus_pkg::*;

  typedef enum logic [1:0] {
    DS_IDLE,                                    // okay, ready
    DS_ERR1,                                    // error, wait
    DS_ERR2                                     // error, ready
  } ds_state_t;

  ds_state_t state_q;
  logic      accept;

  assign accept = bus.sel && bus.ready && trans_active(bus.trans);

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      state_q <= DS_IDLE;
    end else if (accept) begin
      state_q <= DS_ERR1;                       // back-to-back errors allowed
    end else if (state_q == DS_ERR1) begin
      state_q <= DS_ERR2;
    end else begin
      state_q <= DS_IDLE;
    end
  end

  assign bus.readyout = (state_q != DS_ERR1);
  assign bus.resp     = (state_q == DS_IDLE) ? HRESP_OKAY : HRESP_ERROR;
  assign bus.rdata    = '0;

endmodule

`default_nettype wire

// ==== hdl/ahb_slv_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ahb_slv_if;
  import cm3_bus_pkg::*;

  // request side, driven by the decoder
  logic              sel;                       // address-phase hsel
  htrans_t           trans;
  hsize_t            size;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;                     // valid in data phase
  logic              ready;                     // bus-wide hready

  // response side, driven by the slave
  logic              readyout;
  hresp_t            resp;
  logic [DATA_W-1:0] rdata;

  modport master (
    output sel, trans, size, write, addr, wdata, ready,
    input  readyout, resp, rdata
  );

  modport slave (
    input  sel, trans, size, write, addr, wdata, ready,
    output readyout, resp, rdata
  );

endinterface

`default_nettype wire

// ==== hdl/ahb_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_sram #(
  parameter int SRAM_AW = 10                    // word address bits
) (
  input  logic      hclk,
  input  logic      reset_i,
  ahb_slv_if.slave  bus
);
  import cm3_bus_pkg::*;

  logic [DATA_W-1:0]  mem [2**SRAM_AW];         // word array, no init
  logic               accept;                   // address phase taken
  logic               wr_q;                     // write data phase pending
  logic [SRAM_AW+1:0] addr_q;                   // byte address in region
  hsize_t             size_q;
  logic [3:0]         lane_en;

  assign accept = bus.sel && bus.ready && trans_active(bus.trans);

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      wr_q <= 1'b0;
    end else if (bus.ready) begin
      wr_q <= accept && bus.write;
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      addr_q <= bus.addr[SRAM_AW+1:0];
      size_q <= bus.size;
    end
  end

  // --------------------------------------------------------------------------
  // byte lanes from registered size and low address bits
  // --------------------------------------------------------------------------
  always_comb begin
    case (size_q)
      HSIZE_BYTE: lane_en = 4'b0001 << addr_q[1:0];
      HSIZE_HALF: lane_en = addr_q[1] ? 4'b1100 : 4'b0011;
      default:    lane_en = 4'b1111;            // word
    endcase
  end

  // write lands as the data phase closes
  always_ff @(posedge hclk) begin
    if (wr_q && bus.ready) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) begin
          mem[addr_q[SRAM_AW+1:2]][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
    end
  end

  assign bus.rdata    = mem[addr_q[SRAM_AW+1:2]];  // whole word, async read
  assign bus.readyout = 1'b1;                   // zero wait states
  assign bus.resp     = HRESP_OKAY;

endmodule

`default_nettype wire

// ==== hdl/cm3_bus_pkg.sv ====
`default_nettype none

package cm3_bus_pkg;

  // --------------------------------------------------------------------------
  // bus widths and AHB-lite encodings
  // --------------------------------------------------------------------------
  localparam int ADDR_W = 32;                   // haddr width
  localparam int DATA_W = 32;                   // hwdata / hrdata width

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,                      // first beat
    HTRANS_SEQ    = 2'b11                       // burst continuation
  } htrans_t;

  typedef enum logic [2:0] {
    HSIZE_BYTE = 3'b000,
    HSIZE_HALF = 3'b001,
    HSIZE_WORD = 3'b010
  } hsize_t;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_t;

  // address map, only haddr[31:28] is decoded
  localparam logic [ADDR_W-1:0] RAM_BASE = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] MAC_BASE = 32'h4000_0000;

  typedef struct packed {
    logic dflt;                                 // unmapped space
    logic mac;
    logic ram;
  } slave_sel_t;

  // --------------------------------------------------------------------------
  // mac register map
  // --------------------------------------------------------------------------
  localparam logic [7:0] MAC_A_OFS    = 8'h00;
  localparam logic [7:0] MAC_B_OFS    = 8'h04;
  localparam logic [7:0] MAC_CTRL_OFS = 8'h08;
  localparam logic [7:0] MAC_STAT_OFS = 8'h0C;
  localparam logic [7:0] MAC_ACC_OFS  = 8'h10;

  localparam int CTRL_START_BIT = 0;            // self clearing
  localparam int CTRL_CLEAR_BIT = 1;            // self clearing
  localparam int CTRL_IRQEN_BIT = 2;
  localparam int STAT_BUSY_BIT  = 0;
  localparam int STAT_DONE_BIT  = 1;            // write 1 to clear

  function automatic logic trans_active(htrans_t trans);
    return (trans == HTRANS_NONSEQ) || (trans == HTRANS_SEQ);
  endfunction

endpackage

`default_nettype wire

// ==== hdl/cm3_system_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cm3_system_top #(
  parameter int SRAM_AW = 10,                   // 4 KB of sram
  parameter int MAC_W   = 16                    // mac operand width
) (
  input  logic                              hclk,
  input  logic                              reset_i,
  input  logic [cm3_bus_pkg::ADDR_W-1:0]    haddr_i,
  input  cm3_bus_pkg::htrans_t              htrans_i,
  input  cm3_bus_pkg::hsize_t               hsize_i,
  input  logic                              hwrite_i,
  input  logic [cm3_bus_pkg::DATA_W-1:0]    hwdata_i,
  output logic [cm3_bus_pkg::DATA_W-1:0]    hrdata_o,
  output logic                              hready_o,
  output cm3_bus_pkg::hresp_t               hresp_o,
  output logic                              irq_o
);

  // --------------------------------------------------------------------------
  // one slave-side bus per target
  // --------------------------------------------------------------------------
  ahb_slv_if u_ram_bus ();
  ahb_slv_if u_mac_bus ();
  ahb_slv_if u_def_bus ();

  logic                             mac_req;     // regs -> engine handshake
  logic                             mac_ack;
  logic [MAC_W-1:0]                 mac_op_a;
  logic [MAC_W-1:0]                 mac_op_b;
  logic [cm3_bus_pkg::DATA_W-1:0]   mac_acc;     // accumulator into engine
  logic [cm3_bus_pkg::DATA_W-1:0]   mac_result;  // new accumulator back

  ahb_decoder_mux u_ahb_decoder_mux (
    .hclk     (hclk),
    .reset_i  (reset_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .ram_o    (u_ram_bus),
    .mac_o    (u_mac_bus),
    .def_o    (u_def_bus),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),                       // also fans back to slaves
    .hresp_o  (hresp_o)
  );

  ahb_sram #(
    .SRAM_AW (SRAM_AW)
  ) u_ahb_sram (
    .hclk    (hclk),
    .reset_i (reset_i),
    .bus     (u_ram_bus)
  );

  ahb_default_slave u_ahb_default_slave (
    .hclk    (hclk),
    .reset_i (reset_i),
    .bus     (u_def_bus)
  );

  // --------------------------------------------------------------------------
  // mac peripheral, register block plus engine
  // --------------------------------------------------------------------------
  mac_regs #(
    .MAC_W (MAC_W)
  ) u_mac_regs (
    .hclk     (hclk),
    .reset_i  (reset_i),
    .bus      (u_mac_bus),
    .req_o    (mac_req),
    .op_a_o   (mac_op_a),
    .op_b_o   (mac_op_b),
    .acc_o    (mac_acc),
    .ack_i    (mac_ack),
    .result_i (mac_result),
    .irq_o    (irq_o)                           // single interrupt line
  );

  mac_engine #(
    .MAC_W (MAC_W)
  ) u_mac_engine (
    .hclk     (hclk),
    .reset_i  (reset_i),
    .req_i    (mac_req),
    .op_a_i   (mac_op_a),
    .op_b_i   (mac_op_b),
    .acc_i    (mac_acc),
    .ack_o    (mac_ack),
    .result_o (mac_result)
  );

endmodule

`default_nettype wire

// ==== hdl/mac_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_engine #(
  parameter int MAC_W = 16
) (
  input  logic                              hclk,
  input  logic                              reset_i,
  input  logic                              req_i,
  input  logic [MAC_W-1:0]                  op_a_i,
  input  logic [MAC_W-1:0]                  op_b_i,
  input  logic [cm3_bus_pkg::DATA_W-1:0]    acc_i,
  output logic                              ack_o,
  output logic [cm3_bus_pkg::DATA_W-1:0]    result_o
);
  import cm3_bus_pkg::*;

  localparam int CNT_W = $clog2(MAC_W + 1);

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_RUN,                                    // MAC_W shift-add steps
    ENG_ACK                                     // hold ack until req drops
  } eng_state_t;

  eng_state_t        state_q;
  logic [CNT_W-1:0]  cnt_q;                     // step counter
  logic [DATA_W-1:0] mcand_q;                   // shifted left each step
  logic [MAC_W-1:0]  mplier_q;                  // shifted right each step
  logic [DATA_W-1:0] sum_q;                     // acc_in plus partials

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      state_q <= ENG_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ENG_IDLE: begin
          cnt_q <= '0;
          if (req_i) state_q <= ENG_RUN;
        end
        ENG_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(MAC_W - 1)) state_q <= ENG_ACK;  // last step
        end
        ENG_ACK: if (!req_i) state_q <= ENG_IDLE;  // phase 4
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  // datapath, sum wraps mod 2^32
  always_ff @(posedge hclk) begin
    if (state_q == ENG_IDLE && req_i) begin
      mcand_q  <= DATA_W'(op_a_i);
      mplier_q <= op_b_i;
      sum_q    <= acc_i;
    end else if (state_q == ENG_RUN) begin
      if (mplier_q[0]) sum_q <= sum_q + mcand_q;
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  assign ack_o    = (state_q == ENG_ACK);
  assign result_o = sum_q;                      // stable while ack high

endmodule

`default_nettype wire

// ==== hdl/mac_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_regs #(
  parameter int MAC_W = 16
) (
  input  logic                              hclk,
  input  logic                              reset_i,
  ahb_slv_if.slave                          bus,
  output logic                              req_o,
  output logic [MAC_W-1:0]                  op_a_o,
  output logic [MAC_W-1:0]                  op_b_o,
  output logic [cm3_bus_pkg::DATA_W-1:0]    acc_o,
  input  logic                              ack_i,
  input  logic [cm3_bus_pkg::DATA_W-1:0]    result_i,
  output logic                              irq_o
);
  import cm3_bus_pkg::*;

  logic              accept;
  logic              wr_q;                      // write data phase pending
  logic [7:0]        ofs_q;                     // register offset
  logic [MAC_W-1:0]  a_q;
  logic [MAC_W-1:0]  b_q;
  logic              irqen_q;
  logic              done_q;                    // sticky
  logic              req_q;
  logic [DATA_W-1:0] acc_q;
  logic              busy;
  logic              wr_en;

  assign accept = bus.sel && bus.ready && trans_active(bus.trans);
  assign busy   = req_q || ack_i;               // req up until ack down
  assign wr_en  = wr_q && bus.ready;

  always_ff @(posedge hclk) begin
    if (reset_i) begin
      wr_q <= 1'b0;
    end else if (bus.ready) begin
      wr_q <= accept && bus.write;
    end
  end

  always_ff @(posedge hclk) begin
    if (accept) begin
      ofs_q <= bus.addr[7:0];
    end
  end

  // --------------------------------------------------------------------------
  // register writes and the req/ack master side
  // --------------------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (reset_i) begin
      a_q     <= '0;
      b_q     <= '0;
      irqen_q <= 1'b0;
      done_q  <= 1'b0;
      req_q   <= 1'b0;
      acc_q   <= '0;
    end else begin
      if (wr_en && !busy) begin                 // operands frozen while busy
        case (ofs_q)
          MAC_A_OFS: a_q <= bus.wdata[MAC_W-1:0];
          MAC_B_OFS: b_q <= bus.wdata[MAC_W-1:0];
          MAC_CTRL_OFS: begin
            irqen_q <= bus.wdata[CTRL_IRQEN_BIT];
            if (bus.wdata[CTRL_CLEAR_BIT]) acc_q <= '0;
            if (bus.wdata[CTRL_START_BIT]) req_q <= 1'b1;
          end
          default: ;
        endcase
      end
      if (wr_en && ofs_q == MAC_STAT_OFS && bus.wdata[STAT_DONE_BIT]) begin
        done_q <= 1'b0;                         // w1c
      end
      if (req_q && ack_i) begin                 // phase 3, latch and drop req
        acc_q  <= result_i;
        done_q <= 1'b1;
        req_q  <= 1'b0;
      end
    end
  end

  // read mux on the registered offset
  always_comb begin
    bus.rdata = '0;
    case (ofs_q)
      MAC_A_OFS:    bus.rdata = {{(DATA_W-MAC_W){1'b0}}, a_q};
      MAC_B_OFS:    bus.rdata = {{(DATA_W-MAC_W){1'b0}}, b_q};
      MAC_CTRL_OFS: bus.rdata[CTRL_IRQEN_BIT] = irqen_q;  // start/clear read 0
      MAC_STAT_OFS: begin
        bus.rdata[STAT_BUSY_BIT] = busy;
        bus.rdata[STAT_DONE_BIT] = done_q;
      end
      MAC_ACC_OFS:  bus.rdata = acc_q;
      default:      bus.rdata = '0;
    endcase
  end

  assign bus.readyout = 1'b1;                   // zero wait states
  assign bus.resp     = HRESP_OKAY;

  assign req_o  = req_q;
  assign op_a_o = a_q;
  assign op_b_o = b_q;
  assign acc_o  = acc_q;
  assign irq_o  = done_q && irqen_q;

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/cm3_bus_pkg.sv
hdl/ahb_slv_if.sv
hdl/ahb_decoder_mux.sv
hdl/ahb_sram.sv
hdl/ahb_default_slave.sv
hdl/mac_regs.sv
hdl/mac_engine.sv
hdl/cm3_system_top.sv
verif/cm3_system_properties.sv
verif/tb_cm3_system.sv

// ==== verif/cm3_system_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cm3_system_properties (
  input logic                hclk,
  input logic                reset_i,
  input logic                hready_i,
  input cm3_bus_pkg::hresp_t hresp_i,
  input logic                irq_i
);
  import cm3_bus_pkg::*;

  // bus parked ready/okay while in reset
  reset_quiet: assert property (@(posedge hclk)
    reset_i |-> hready_i && hresp_i == HRESP_OKAY)
    else $error("hready_o/hresp_o not ready and okay during reset");

  // two-cycle error response
  error_second_cycle: assert property (@(posedge hclk) disable iff (reset_i)
    (hresp_i == HRESP_ERROR && !hready_i) |=> (hresp_i == HRESP_ERROR && hready_i))
    else $error("first error cycle not followed by error with hready_o high");

  // error with ready only closes a two-cycle error
  okay_when_ready: assert property (@(posedge hclk) disable iff (reset_i)
    hready_i |-> (hresp_i == HRESP_OKAY) || $past(hresp_i == HRESP_ERROR && !hready_i))
    else $error("hresp_o error with hready_o high outside an error response");

  irq_quiet_in_reset: assert property (@(posedge hclk)
    reset_i |-> !$rose(irq_i))
    else $error("irq_o rose while reset_i was high");

endmodule

bind cm3_system_top cm3_system_properties u_cm3_system_properties (
  .hclk     (hclk),
  .reset_i  (reset_i),
  .hready_i (hready_o),
  .hresp_i  (hresp_o),
  .irq_i    (irq_o)
);

`default_nettype wire

// ==== verif/tb_cm3_system.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cm3_system;
  import cm3_bus_pkg::*;

  localparam int SRAM_AW    = 10;
  localparam int MAC_W      = 16;
  localparam int DRIVE_DLY  = 1;                // ns after the rising edge
  localparam int MAX_CYCLES = 6000;             // about 1000 needed plus margin
  localparam int MAX_POLLS  = 100;              // status reads per mac operation

  logic              hclk;
  logic              reset_i;
  logic [ADDR_W-1:0] haddr_i;
  htrans_t           htrans_i;
  hsize_t            hsize_i;
  logic              hwrite_i;
  logic [DATA_W-1:0] hwdata_i;
  logic [DATA_W-1:0] hrdata_o;
  logic              hready_o;
  hresp_t            hresp_o;
  logic              irq_o;

  integer            seed = 32'h04b9_aee0;
  int                n_tests;
  int                n_checks;
  int                n_errors;
  int                cycle_cnt;
  logic [31:0]       mem_model [logic [31:0]];  // keyed by word address
  logic [31:0]       written_addrs [$];
  logic [31:0]       acc_model;

  cm3_system_top #(
    .SRAM_AW (SRAM_AW),
    .MAC_W   (MAC_W)
  ) u_cm3_system_top (
    .hclk     (hclk),
    .reset_i  (reset_i),
    .haddr_i  (haddr_i),
    .htrans_i (htrans_i),
    .hsize_i  (hsize_i),
    .hwrite_i (hwrite_i),
    .hwdata_i (hwdata_i),
    .hrdata_o (hrdata_o),
    .hready_o (hready_o),
    .hresp_o  (hresp_o),
    .irq_o    (irq_o)
  );

  initial begin
    hclk = 1'b0;
    forever #50 hclk = ~hclk;                   // 100 ns period
  end

  always @(posedge hclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] mac_ref(logic [31:0] acc, logic [MAC_W-1:0] a,
                                          logic [MAC_W-1:0] b);
    logic [31:0] prod;
    prod = 32'(a) * 32'(b);
    return acc + prod;                          // wraps mod 2^32
  endfunction

  function automatic logic [3:0] lane_mask(hsize_t size, logic [1:0] ofs);
    logic [3:0] mask;
    for (int i = 0; i < 4; i++) begin
      mask[i] = (size == HSIZE_WORD) ||
                (size == HSIZE_HALF && i[1] == ofs[1]) ||
                (i[1:0] == ofs);
    end
    return mask;
  endfunction

  function automatic logic [31:0] model_read(logic [31:0] addr);
    return mem_model.exists(addr >> 2) ? mem_model[addr >> 2] : 32'h0;
  endfunction

  function automatic void model_write(logic [31:0] addr, hsize_t size, logic [31:0] data);
    logic [31:0] word;
    logic [3:0]  mask;
    word = model_read(addr);
    mask = lane_mask(size, addr[1:0]);
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) word[8*i +: 8] = data[8*i +: 8];
    end
    mem_model[addr >> 2] = word;
  endfunction

  function automatic logic [31:0] ram_word_addr(logic [31:0] rnd);
    return RAM_BASE + ((rnd % (32'd4 << SRAM_AW)) & ~32'h3);  // aligned, in range
  endfunction

  function automatic logic [31:0] mac_addr(logic [7:0] ofs);
    return {MAC_BASE[31:8], ofs};
  endfunction

  task automatic compare_values(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      $display("test %0d %s: %0d errors", n_tests, name, n_errors - errs_before);
    end
  endtask

  // --------------------------------------------------------------------------
  // bus master, one transfer at a time
  // --------------------------------------------------------------------------
  task automatic wait_ready();
    while (!hready_o) begin                     // value holds until next edge
      @(posedge hclk);
      #DRIVE_DLY;
    end
  endtask

  task automatic ahb_write(input logic [31:0] addr, input hsize_t size,
                           input logic [31:0] data, output hresp_t resp);
    haddr_i  = addr;
    htrans_i = HTRANS_NONSEQ;
    hsize_i  = size;
    hwrite_i = 1'b1;
    wait_ready();                               // address held while stalled
    @(posedge hclk);
    #DRIVE_DLY;
    htrans_i = HTRANS_IDLE;                     // data phase
    hwrite_i = 1'b0;
    hwdata_i = data;
    wait_ready();
    resp = hresp_o;
    @(posedge hclk);
    #DRIVE_DLY;
  endtask

  task automatic ahb_read(input logic [31:0] addr, input hsize_t size,
                          output logic [31:0] data, output hresp_t resp);
    haddr_i  = addr;
    htrans_i = HTRANS_NONSEQ;
    hsize_i  = size;
    hwrite_i = 1'b0;
    wait_ready();
    @(posedge hclk);
    #DRIVE_DLY;
    htrans_i = HTRANS_IDLE;
    wait_ready();
    data = hrdata_o;                            // sampled before the closing edge
    resp = hresp_o;
    @(posedge hclk);
    #DRIVE_DLY;
  endtask

  task automatic mac_write(input logic [7:0] ofs, input logic [31:0] data);
    hresp_t resp;
    ahb_write(mac_addr(ofs), HSIZE_WORD, data, resp);
    compare_values("hresp_o", HRESP_OKAY, resp);
  endtask

  task automatic mac_read(input logic [7:0] ofs, output logic [31:0] data);
    hresp_t resp;
    ahb_read(mac_addr(ofs), HSIZE_WORD, data, resp);
    compare_values("hresp_o", HRESP_OKAY, resp);
  endtask

  task automatic wait_mac_idle(input logic irq_must_stay_low);
    logic [31:0] stat;
    int          polls;
    polls = 0;
    do begin
      mac_read(MAC_STAT_OFS, stat);
      if (irq_must_stay_low) compare_values("irq_o", 32'h0, irq_o);
      polls++;
    end while (stat[STAT_BUSY_BIT] && polls < MAX_POLLS);
    if (stat[STAT_BUSY_BIT]) begin
      n_errors++;
      $display("mac still busy after %0d status reads at %0d ns", polls, $time);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------
  task automatic test_sram_words();
    logic [31:0] addr;
    logic [31:0] data;
    hresp_t      resp;
    int          errs;
    errs = n_errors;
    for (int i = 0; i < 64; i++) begin
      addr = ram_word_addr($random(seed));
      data = $random(seed);
      ahb_write(addr, HSIZE_WORD, data, resp);
      compare_values("hresp_o", HRESP_OKAY, resp);
      model_write(addr, HSIZE_WORD, data);
      written_addrs.push_back(addr);
    end
    foreach (written_addrs[i]) begin
      ahb_read(written_addrs[i], HSIZE_WORD, data, resp);
      compare_values("hrdata_o", model_read(written_addrs[i]), data);
    end
    report_test("sram word write/read", errs);
  endtask

  task automatic test_sram_lanes();
    logic [31:0] base;
    logic [31:0] data;
    logic [1:0]  ofs;
    hsize_t      size;
    hresp_t      resp;
    int          errs;
    errs = n_errors;
    for (int k = 0; k < 12; k++) begin
      size = (k % 6 < 4) ? HSIZE_BYTE : HSIZE_HALF;
      ofs  = (k % 6 < 4) ? 2'(k % 6) : 2'((k % 6 - 4) * 2);  // bytes 0..3, halves 0 and 2
      base = ram_word_addr($random(seed));
      data = $random(seed);
      ahb_write(base, HSIZE_WORD, data, resp);  // known background word
      model_write(base, HSIZE_WORD, data);
      data = $random(seed);
      ahb_write(base + 32'(ofs), size, data, resp);
      compare_values("hresp_o", HRESP_OKAY, resp);
      model_write(base + 32'(ofs), size, data);
      ahb_read(base, HSIZE_WORD, data, resp);
      compare_values("hrdata_o", model_read(base), data);
    end
    report_test("sram byte/halfword lanes", errs);
  endtask

  task automatic test_unmapped();
    logic [31:0] data;
    hresp_t      resp;
    int          errs;
    errs = n_errors;
    ahb_write(32'h0000_0120, HSIZE_WORD, 32'hdead_beef, resp);
    compare_values("hresp_o", HRESP_ERROR, resp);
    ahb_read(32'h0000_0200, HSIZE_WORD, data, resp);
    compare_values("hresp_o", HRESP_ERROR, resp);
    ahb_read(written_addrs[0], HSIZE_WORD, data, resp);  // right after the error
    compare_values("hresp_o", HRESP_OKAY, resp);
    compare_values("hrdata_o", model_read(written_addrs[0]), data);
    report_test("unmapped access", errs);
  endtask

  task automatic test_mac_ops();
    logic [MAC_W-1:0] a;
    logic [MAC_W-1:0] b;
    logic [31:0]      rd;
    int               errs;
    errs = n_errors;
    mac_write(MAC_CTRL_OFS, 32'h1 << CTRL_CLEAR_BIT);
    acc_model = '0;
    for (int i = 0; i < 8; i++) begin
      a = MAC_W'($random(seed));
      b = MAC_W'($random(seed));
      mac_write(MAC_A_OFS, 32'(a));
      mac_write(MAC_B_OFS, 32'(b));
      mac_write(MAC_CTRL_OFS, 32'h1 << CTRL_START_BIT);
      mac_write(MAC_A_OFS, 32'(~a));           // lands while busy
      wait_mac_idle(1'b0);
      acc_model = mac_ref(acc_model, a, b);
      mac_read(MAC_ACC_OFS, rd);
      compare_values("acc", acc_model, rd);
      mac_read(MAC_A_OFS, rd);
      compare_values("op_a", 32'(a), rd);
      mac_write(MAC_STAT_OFS, 32'h1 << STAT_DONE_BIT);
    end
    mac_write(MAC_CTRL_OFS, 32'h1 << CTRL_CLEAR_BIT);  // accumulator is nonzero here
    acc_model = '0;
    mac_read(MAC_ACC_OFS, rd);
    compare_values("acc", acc_model, rd);
    report_test("mac accumulate", errs);
  endtask

  task automatic test_irq();
    logic [MAC_W-1:0] a;
    logic [MAC_W-1:0] b;
    logic [31:0]      rd;
    int               errs;
    errs = n_errors;
    a = MAC_W'($random(seed));
    b = MAC_W'($random(seed));
    mac_write(MAC_A_OFS, 32'(a));
    mac_write(MAC_B_OFS, 32'(b));
    mac_write(MAC_CTRL_OFS, (32'h1 << CTRL_IRQEN_BIT) | (32'h1 << CTRL_START_BIT));
    wait_mac_idle(1'b0);
    acc_model = mac_ref(acc_model, a, b);
    compare_values("irq_o", 32'h1, irq_o);
    mac_write(MAC_STAT_OFS, 32'h1 << STAT_DONE_BIT);
    compare_values("irq_o", 32'h0, irq_o);
    mac_write(MAC_CTRL_OFS, 32'h1 << CTRL_START_BIT);  // irq disabled
    wait_mac_idle(1'b1);
    acc_model = mac_ref(acc_model, a, b);
    compare_values("irq_o", 32'h0, irq_o);
    mac_read(MAC_ACC_OFS, rd);
    compare_values("acc", acc_model, rd);
    report_test("mac interrupt", errs);
  endtask

  task automatic test_reset_mid_op();
    logic [31:0] rd;
    int          errs;
    errs = n_errors;
    mac_write(MAC_STAT_OFS, 32'h1 << STAT_DONE_BIT);
    mac_write(MAC_CTRL_OFS, (32'h1 << CTRL_IRQEN_BIT) | (32'h1 << CTRL_START_BIT));
    reset_i = 1'b1;                             // engine still running
    repeat (MAC_W + 4) @(posedge hclk);         // past the point where ack would rise
    #DRIVE_DLY;
    reset_i = 1'b0;
    compare_values("irq_o", 32'h0, irq_o);
    mac_read(MAC_STAT_OFS, rd);
    compare_values("status", 32'h0, rd);
    mac_read(MAC_CTRL_OFS, rd);
    compare_values("ctrl", 32'h0, rd);
    mac_read(MAC_ACC_OFS, rd);
    compare_values("acc", 32'h0, rd);
    mac_read(MAC_A_OFS, rd);
    compare_values("op_a", 32'h0, rd);
    acc_model = '0;
    report_test("reset during mac operation", errs);
  endtask

  initial begin
    reset_i   = 1'b1;
    haddr_i   = '0;
    htrans_i  = HTRANS_IDLE;
    hsize_i   = HSIZE_WORD;
    hwrite_i  = 1'b0;
    hwdata_i  = '0;
    n_tests   = 0;
    n_checks  = 0;
    n_errors  = 0;
    cycle_cnt = 0;
    acc_model = '0;
    repeat (10) @(posedge hclk);
    #DRIVE_DLY;
    reset_i = 1'b0;
    test_sram_words();
    test_sram_lanes();
    test_unmapped();
    test_mac_ops();
    test_irq();
    test_reset_mid_op();
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
